/* songData.svh */
`ifndef SONG_DATA_SVH
`define SONG_DATA_SVH

// word layout {valid, code, dur}, an all zero word ends a song
localparam songEntry_t songTable [romDepth] = '{
        // idle terminator at address 0
        8'h00,
        // song 0, twinkle twinkle
        8'hA4, 8'hA4, 8'hB4, 8'hB4, 8'hB8, 8'hB8, 8'hB5,
        8'hB0, 8'hB0, 8'hAC, 8'hAC, 8'hA8, 8'hA8, 8'hA5,
        8'hB4, 8'hB4, 8'hB0, 8'hB0, 8'hAC, 8'hAC, 8'hA9,
        8'hB4, 8'hB4, 8'hB0, 8'hB0, 8'hAC, 8'hAC, 8'hA9,
        8'hA4, 8'hA4, 8'hB4, 8'hB4, 8'hB8, 8'hB8, 8'hB5,
        8'hB0, 8'hB0, 8'hAC, 8'hAC, 8'hA8, 8'hA8, 8'hA5,
        8'h00,
        // song 1, ode to joy
        8'hAC, 8'hAC, 8'hB0, 8'hB4, 8'hB4, 8'hB0, 8'hAC, 8'hA8,
        8'hA4, 8'hA4, 8'hA8, 8'hAC, 8'hAC, 8'hA8, 8'hA9,
        8'hAC, 8'hAC, 8'hB0, 8'hB4, 8'hB4, 8'hB0, 8'hAC, 8'hA8,
        8'hA4, 8'hA4, 8'hA8, 8'hAC, 8'hA8, 8'hA4, 8'hA5,
        8'hA8, 8'hA8, 8'hAC, 8'hA4, 8'hA8, 8'hB0, 8'hAC, 8'hA4,
        8'hA8, 8'hB0, 8'hAC, 8'hA8, 8'hA4, 8'hA8, 8'hB5,
        8'hAC, 8'hAC, 8'hB0, 8'hB4, 8'hB4, 8'hB0, 8'hAC, 8'hA8,
        8'hA4, 8'hA4, 8'hA8, 8'hAC, 8'hA8, 8'hA4, 8'hA5,
        8'h00,
        // song 2, the only one with long notes
        8'hA5, 8'hA4, 8'hAC, 8'hB5, 8'hB9, 8'hB7, 8'hAD,
        8'hA5, 8'hA4, 8'hAC, 8'hB5, 8'hB9, 8'hB7, 8'hAD,
        8'hAD, 8'hB5, 8'hB9, 8'hB5, 8'hC1, 8'hB9, 8'hB6,
        8'hA5, 8'hA4, 8'hAC, 8'hB5, 8'hB9, 8'hC1, 8'hB9, 8'hB6,
        8'hB5, 8'hB5, 8'hBA, 8'hB8, 8'hC1, 8'hC0, 8'hB8, 8'hB6,
        8'hB5, 8'hB4, 8'hB8, 8'hB6, 8'hB6,
        8'hB5, 8'hB4, 8'hB8, 8'hB6, 8'hB6,
        8'h00,
        // song 3, farm tune
        8'hC0, 8'hC0, 8'hC0, 8'hB4, 8'hB8, 8'hB8, 8'hB5,
        8'hC8, 8'hC8, 8'hC4, 8'hC4, 8'hC1,
        8'hC0, 8'hC0, 8'hC0, 8'hB4, 8'hB8, 8'hB8, 8'hB5,
        8'hC8, 8'hC8, 8'hC4, 8'hC4, 8'hC1,
        // trailing terminator
        8'h00
};

`endif

/* musicPkg.sv */
`default_nettype none

package musicPkg;

        ////////////////////////////////////////////////////////////////////////////
        // scalar types
        ////////////////////////////////////////////////////////////////////////////

        // note code, three octaves from C3 up to C6
        typedef logic [4:0] noteCode_t;
        // duration code, only passed through to the player
        typedef logic [1:0] duration_t;
        typedef logic [1:0] songId_t;
        typedef logic [7:0] romAddr_t;
        // divider count for the tone generator
        typedef logic [19:0] notePeriod_t;

        // one song memory word, valid flag in the top bit
        typedef struct packed {
                logic      valid;
                noteCode_t code;
                duration_t dur;
        } songEntry_t;

        ////////////////////////////////////////////////////////////////////////////
        // note codes
        ////////////////////////////////////////////////////////////////////////////

        localparam noteCode_t noteC3 = 5'd0;
        localparam noteCode_t noteD3 = 5'd1;
        localparam noteCode_t noteE3 = 5'd2;
        localparam noteCode_t noteF3 = 5'd3;
        localparam noteCode_t noteG3 = 5'd4;
        localparam noteCode_t noteA3 = 5'd5;
        localparam noteCode_t noteB3 = 5'd6;
        // code 7 unused, code 8 is silence
        localparam noteCode_t restCode = 5'd8;
        localparam noteCode_t noteC4 = 5'd9;
        localparam noteCode_t noteD4 = 5'd10;
        localparam noteCode_t noteE4 = 5'd11;
        localparam noteCode_t noteF4 = 5'd12;
        localparam noteCode_t noteG4 = 5'd13;
        localparam noteCode_t noteA4 = 5'd14;
        localparam noteCode_t noteB4 = 5'd15;
        localparam noteCode_t noteC5 = 5'd16;
        localparam noteCode_t noteD5 = 5'd17;
        localparam noteCode_t noteE5 = 5'd18;
        localparam noteCode_t noteF5 = 5'd19;
        localparam noteCode_t noteG5 = 5'd20;
        localparam noteCode_t noteA5 = 5'd21;
        localparam noteCode_t noteB5 = 5'd22;
        localparam noteCode_t noteC6 = 5'd23;

        // song memory size and layout
        localparam int romDepth = 178;
        // first word of each song, right after its leading terminator
        localparam romAddr_t songBase [4] = '{8'd1, 8'd44, 8'd105, 8'd153};
        localparam int songLength [4] = '{42, 60, 47, 24};

endpackage

`default_nettype wire

/* busPkg.sv */
`default_nettype none

package busPkg;

        // APB request from the bus master
        typedef struct packed {
                logic        psel;
                logic        penable;
                logic        pwrite;
                logic [7:0]  paddr;
                logic [31:0] pwdata;
        } apbReq_t;

        // APB response back to the master
        typedef struct packed {
                logic [31:0] prdata;
                logic        pready;
                logic        pslverr;
        } apbRsp_t;

        // register map
        localparam logic [7:0] ctrlAddr = 8'h00;
        localparam logic [7:0] statusAddr = 8'h04;
        // field positions
        localparam int ctrlPlayBit = 8;
        localparam int statusPlayBit = 0;
        localparam int statusSongLsb = 4;

endpackage

`default_nettype wire

/* songRom.sv */
`timescale 1ns/1ps
`default_nettype none

module songRom #(
        parameter int ROM_DEPTH = musicPkg::romDepth
) (
        input wire musicPkg::romAddr_t addr,
        output musicPkg::songEntry_t entry
);
        import musicPkg::*;

        `include "songData.svh"

        logic inTable;

        // anything past the stored words or the configured depth
        // reads back as a terminator
        assign inTable = (int'(addr) < ROM_DEPTH) && (int'(addr) < romDepth);

        // asynchronous read, no clock here
        always_comb begin
                if (inTable) begin
                        entry = songTable[addr];
                end else begin
                        entry = '0;
                end
        end

endmodule

`default_nettype wire

/* notePeriodLut.sv */
`timescale 1ns/1ps
`default_nettype none

module notePeriodLut (
        input wire musicPkg::noteCode_t code,
        output musicPkg::notePeriod_t period
);
        import musicPkg::*;

        ////////////////////////////////////////////////////////////////////////////
        // tuning table
        ////////////////////////////////////////////////////////////////////////////

        // divider counts, roughly halving per octave
        always_comb begin
                case (code)
                        // low octave
                        noteC3: period = 20'h5D2EF;
                        noteD3: period = 20'h530A8;
                        noteE3: period = 20'h49FB6;
                        noteF3: period = 20'h45C12;
                        noteG3: period = 20'h3E47E;
                        noteA3: period = 20'h377C8;
                        noteB3: period = 20'h316BD;
                        // middle octave
                        noteC4: period = 20'h2EA85;
                        noteD4: period = 20'h29854;
                        noteE4: period = 20'h24FDB;
                        noteF4: period = 20'h22E09;
                        noteG4: period = 20'h1F23F;
                        noteA4: period = 20'h1BBE4;
                        noteB4: period = 20'h18B5E;
                        // high octave plus top C
                        noteC5: period = 20'h17572;
                        noteD5: period = 20'h14CBA;
                        noteE5: period = 20'h127ED;
                        noteF5: period = 20'h117D1;
                        noteG5: period = 20'h0F91F;
                        noteA5: period = 20'h0DDF2;
                        noteB5: period = 20'h0C5AF;
                        noteC6: period = 20'h0BA8B;
                        // rest and unused codes stay silent
                        default: period = '0;
                endcase
        end

endmodule

`default_nettype wire

/* songSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module songSequencer #(
        parameter int ROM_DEPTH = musicPkg::romDepth
) (
        input wire playSound,
        input wire start,
        input wire logic playStart,
        input wire musicPkg::songId_t playSong,
        output musicPkg::romAddr_t romAddr,
        input wire musicPkg::songEntry_t entry,
        output musicPkg::noteCode_t noteCode,
        output musicPkg::duration_t duration,
        output logic noteValid,
        output logic playing
);
        import musicPkg::*;

        logic atLastWord;

        // pointer on the final memory word, next step wraps to idle
        assign atLastWord = (int'(romAddr) >= ROM_DEPTH - 1);

        ////////////////////////////////////////////////////////////////////////////
        // pointer and note registers, one word per note tick
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge playSound or posedge start) begin
                if (start) begin
                        romAddr <= '0;
                        playing <= 1'b0;
                        noteValid <= 1'b0;
                        noteCode <= restCode;
                        duration <= '0;
                end else if (playStart) begin
                        // load song base, silent for this one tick
                        romAddr <= songBase[playSong];
                        playing <= 1'b1;
                        noteValid <= 1'b0;
                        noteCode <= restCode;
                        duration <= '0;
                end else if (playing) begin
                        if (entry.valid) begin
                                noteValid <= 1'b1;
                                noteCode <= entry.code;
                                duration <= entry.dur;
                                romAddr <= atLastWord ? '0 : romAddr + 1'b1;
                        end else begin
                                // terminator reached, park on the idle word
                                noteValid <= 1'b0;
                                noteCode <= restCode;
                                duration <= '0;
                                playing <= 1'b0;
                                romAddr <= '0;
                        end
                end
        end

endmodule

`default_nettype wire

/* songCtrlRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module songCtrlRegs (
        input wire playSound,
        input wire start,
        input wire busPkg::apbReq_t apbReq,
        output busPkg::apbRsp_t apbRsp,
        input wire logic playing,
        output logic playStart,
        output musicPkg::songId_t playSong
);
        import busPkg::*;
        import musicPkg::*;

        logic accessPhase;
        logic ctrlHit;
        logic statusHit;
        logic badXfer;
        logic ctrlWrite;
        logic playWrite;
        logic [31:0] readData;
        // song picked by the last play write
        songId_t curSong;

        ////////////////////////////////////////////////////////////////////////////
        // address decode
        ////////////////////////////////////////////////////////////////////////////

        // pready is tied high, so every access phase completes
        assign accessPhase = apbReq.psel && apbReq.penable;
        assign ctrlHit = (apbReq.paddr == ctrlAddr);
        assign statusHit = (apbReq.paddr == statusAddr);
        // unknown address or write to the read only status
        assign badXfer = accessPhase && (!(ctrlHit || statusHit) || (statusHit && apbReq.pwrite));
        assign ctrlWrite = accessPhase && apbReq.pwrite && ctrlHit;
        assign playWrite = ctrlWrite && apbReq.pwdata[ctrlPlayBit];

        always_ff @(posedge playSound or posedge start) begin
                if (start) begin
                        playSong <= '0;
                        curSong <= '0;
                        playStart <= 1'b0;
                end else begin
                        // single tick pulse toward the sequencer
                        playStart <= playWrite;
                        if (ctrlWrite) begin
                                playSong <= apbReq.pwdata[1:0];
                        end
                        if (playWrite) begin
                                curSong <= apbReq.pwdata[1:0];
                        end
                end
        end

        // read mux
        always_comb begin
                readData = '0;
                if (ctrlHit) begin
                        readData[1:0] = playSong;
                end else if (statusHit) begin
                        readData[statusPlayBit] = playing;
                        readData[statusSongLsb +: 2] = curSong;
                end
        end

        // errored reads return zero
        assign apbRsp.prdata = (accessPhase && !apbReq.pwrite && !badXfer) ? readData : '0;
        assign apbRsp.pready = 1'b1;
        assign apbRsp.pslverr = badXfer;

endmodule

`default_nettype wire

/* musicBoxTop.sv */
`timescale 1ns/1ps
`default_nettype none

module musicBoxTop #(
        parameter int ROM_DEPTH = musicPkg::romDepth
) (
        input wire playSound,
        input wire start,
        input wire busPkg::apbReq_t apbReq,
        output busPkg::apbRsp_t apbRsp,
        output musicPkg::notePeriod_t notePeriod,
        output musicPkg::duration_t duration,
        output logic noteValid,
        output logic playing
);
        import musicPkg::*;

        // register block to sequencer
        logic playStart;
        songId_t playSong;
        // sequencer to memory and tuning table
        romAddr_t romAddr;
        songEntry_t entry;
        noteCode_t noteCode;

        songCtrlRegs ctrlRegs_i (
                .playSound (playSound),
                .start     (start),
                .apbReq    (apbReq),
                .apbRsp    (apbRsp),
                .playing   (playing),
                .playStart (playStart),
                .playSong  (playSong)
        );

        songSequencer #(.ROM_DEPTH(ROM_DEPTH)) sequencer_i (
                .playSound (playSound),
                .start     (start),
                .playStart (playStart),
                .playSong  (playSong),
                .romAddr   (romAddr),
                .entry     (entry),
                .noteCode  (noteCode),
                .duration  (duration),
                .noteValid (noteValid),
                .playing   (playing)
        );

        songRom #(.ROM_DEPTH(ROM_DEPTH)) rom_i (
                .addr  (romAddr),
                .entry (entry)
        );

        notePeriodLut lut_i (
                .code   (noteCode),
                .period (notePeriod)
        );

endmodule

`default_nettype wire

/* musicBoxTbUtil.svh */
`ifndef MUSIC_BOX_TB_UTIL_SVH
`define MUSIC_BOX_TB_UTIL_SVH

        ////////////////////////////////////////////////////////////////////////////
        // expected values
        ////////////////////////////////////////////////////////////////////////////

        // note count per song
        localparam int songLengthExp [4] = '{42, 60, 47, 24};
        // opening pitch per song, C4 E4 C4 C5
        localparam notePeriod_t firstPeriodExp [4] = '{
                20'h2EA85, 20'h24FDB, 20'h2EA85, 20'h17572
        };
        localparam int waitLimit = 16;
        // longest song plus its load tick, with margin
        localparam int noteLimit = 100;

        ////////////////////////////////////////////////////////////////////////////
        // checking and reporting
        ////////////////////////////////////////////////////////////////////////////

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
                checkCount++;
                assert (got === expected) else begin
                        errorCount++;
                        $display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                                 $time, name, got, expected);
                end
        endtask

        task automatic reportTimeout(input string what);
                errorCount++;
                $display("timeout at %0t ns because %s", $time, what);
        endtask

        // one line per finished test
        task automatic endTest(input string name);
                testCount++;
                $display("%s finished with %0d errors", name, errorCount - testStartErrors);
                testStartErrors = errorCount;
        endtask

        // taps at bits 32 22 2 1
        // stepped once per bit taken
        function automatic logic [31:0] randomBits(input int count);
                logic [31:0] value;
                logic newBit;
                int i;
                value = '0;
                for (i = 0; i < count; i++) begin
                        newBit = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
                        lfsrState = {lfsrState[30:0], newBit};
                        value = {value[30:0], newBit};
                end
                return value;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // bus and note helpers
        ////////////////////////////////////////////////////////////////////////////

        // one APB transfer, setup then access
        task automatic apbXfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
                int cycles;
                @(posedge playSound);
                #1;
                apbReq.psel = 1'b1;
                apbReq.penable = 1'b0;
                apbReq.pwrite = write;
                apbReq.paddr = addr;
                apbReq.pwdata = wdata;
                @(posedge playSound);
                #1;
                apbReq.penable = 1'b1;
                #1;
                cycles = 0;
                // stay in access until pready
                while (!apbRsp.pready && cycles < waitLimit) begin
                        @(posedge playSound);
                        #2;
                        cycles++;
                end
                if (!apbRsp.pready) begin
                        reportTimeout("pready never rose in an access phase");
                end
                rdata = apbRsp.prdata;
                err = apbRsp.pslverr;
                // transfer completes on this edge
                @(posedge playSound);
                #1;
                apbReq = '0;
        endtask

        task automatic waitForPlaying();
                int cycles;
                cycles = 0;
                while (!playing && cycles < waitLimit) begin
                        @(posedge playSound);
                        #1;
                        cycles++;
                end
                if (!playing) begin
                        reportTimeout("playing never rose after a play write");
                end
        endtask

        // counts note ticks until the terminator clears playing
        task automatic countNotes(output int notes, output notePeriod_t firstPeriod);
                int cycles;
                notes = 0;
                firstPeriod = '0;
                durCount = '{default: 0};
                waitForPlaying();
                cycles = 0;
                while (playing && cycles < noteLimit) begin
                        @(posedge playSound);
                        #1;
                        cycles++;
                        if (noteValid) begin
                                if (notes == 0) begin
                                        firstPeriod = notePeriod;
                                end
                                durCount[duration]++;
                                notes++;
                        end
                end
                if (playing) begin
                        reportTimeout("playing never fell at the end of a song");
                end
        endtask

`endif

/* musicBoxTb.sv */
`timescale 1ns/1ps
`default_nettype none

module musicBoxTb;
        import musicPkg::*;
        import busPkg::*;

        logic playSound;
        logic start;
        apbReq_t apbReq;
        apbRsp_t apbRsp;
        notePeriod_t notePeriod;
        duration_t duration;
        logic noteValid;
        logic playing;

        // shared with the helper tasks
        int errorCount = 0;
        int checkCount = 0;
        int testCount = 0;
        int testStartErrors = 0;
        // notes per duration code in the last song
        int durCount [4];
        logic [31:0] lfsrState;

        `include "musicBoxTbUtil.svh"

        musicBoxTop #(.ROM_DEPTH(romDepth)) dut_i (
                .playSound  (playSound),
                .start      (start),
                .apbReq     (apbReq),
                .apbRsp     (apbRsp),
                .notePeriod (notePeriod),
                .duration   (duration),
                .noteValid  (noteValid),
                .playing    (playing)
        );

        // 20 ns note clock
        always #10 playSound = ~playSound;

        ////////////////////////////////////////////////////////////////////////////
        // invariants on every edge
        ////////////////////////////////////////////////////////////////////////////

        assert property (@(posedge playSound) disable iff (start) apbRsp.pready)
        else begin
                errorCount++;
                $display("FAILED at %0t ns: pready is 0, expected 1", $time);
        end

        // a note only sounds while a song plays
        assert property (@(posedge playSound) disable iff (start) noteValid |-> playing)
        else begin
                errorCount++;
                $display("FAILED at %0t ns: playing is 0 with noteValid 1, expected 1", $time);
        end

        assert property (@(posedge playSound) disable iff (start)
                         noteValid |-> notePeriod != 0)
        else begin
                errorCount++;
                $display("FAILED at %0t ns: notePeriod is 0, expected nonzero", $time);
        end

        initial begin
                logic [31:0] rdata;
                logic err;
                int notes;
                notePeriod_t firstPeriod;
                int order [4];
                int i;
                int pick;
                int swap;
                int song;
                int song0Long;
                int song2Dur2;
                int song2Dur3;

                lfsrState = 32'ha16c;
                playSound = 1'b0;
                start = 1'b1;
                apbReq = '0;
                song0Long = 0;
                song2Dur2 = 0;
                song2Dur3 = 0;
                repeat (10) @(posedge playSound);
                #1;
                start = 1'b0;

                ////////////////////////////////////////////////////////////////////
                // idle state after reset
                ////////////////////////////////////////////////////////////////////

                checkValue("noteValid", noteValid, 0);
                checkValue("playing", playing, 0);
                checkValue("notePeriod", notePeriod, 0);
                apbXfer(1'b0, statusAddr, 32'h0, rdata, err);
                checkValue("status prdata", rdata, 0);
                checkValue("pslverr", err, 0);
                apbXfer(1'b0, ctrlAddr, 32'h0, rdata, err);
                checkValue("ctrl prdata", rdata, 0);
                endTest("test 1 reset state");

                ////////////////////////////////////////////////////////////////////
                // every song once, shuffled order
                ////////////////////////////////////////////////////////////////////

                order = '{0, 1, 2, 3};
                for (i = 3; i > 0; i--) begin
                        pick = randomBits(2) % (i + 1);
                        swap = order[i];
                        order[i] = order[pick];
                        order[pick] = swap;
                end
                for (i = 0; i < 4; i++) begin
                        song = order[i];
                        // idle gap of 0 to 7 ticks
                        repeat (randomBits(3)) @(posedge playSound);
                        apbXfer(1'b1, ctrlAddr, 32'h100 | song, rdata, err);
                        countNotes(notes, firstPeriod);
                        checkValue($sformatf("song %0d noteValid cycles", song), notes,
                                   songLengthExp[song]);
                        checkValue($sformatf("song %0d first notePeriod", song), firstPeriod,
                                   firstPeriodExp[song]);
                        if (song == 0) begin
                                song0Long = durCount[2] + durCount[3];
                        end
                        if (song == 2) begin
                                song2Dur2 = durCount[2];
                                song2Dur3 = durCount[3];
                        end
                end
                endTest("test 2 song lengths");

                // durations seen during test 2
                checkValue("song 2 duration 3 notes", song2Dur3, 2);
                checkValue("song 2 duration 2 present", song2Dur2 > 0, 1);
                checkValue("song 0 notes above duration 1", song0Long, 0);
                endTest("test 3 durations");

                ////////////////////////////////////////////////////////////////////
                // bus errors and restart, both inside song 1
                ////////////////////////////////////////////////////////////////////

                apbXfer(1'b1, ctrlAddr, 32'h101, rdata, err);
                waitForPlaying();
                apbXfer(1'b0, 8'h08, 32'h0, rdata, err);
                checkValue("unknown read pslverr", err, 1);
                checkValue("unknown read prdata", rdata, 0);
                // would start song 2 if it got through
                apbXfer(1'b1, statusAddr, 32'h102, rdata, err);
                checkValue("status write pslverr", err, 1);
                checkValue("status write prdata", rdata, 0);
                checkValue("playing", playing, 1);
                apbXfer(1'b0, ctrlAddr, 32'h0, rdata, err);
                checkValue("ctrl prdata", rdata, 1);
                apbXfer(1'b0, statusAddr, 32'h0, rdata, err);
                checkValue("status prdata", rdata, 32'h11);
                endTest("test 4 bus errors");

                apbXfer(1'b1, ctrlAddr, 32'h103, rdata, err);
                countNotes(notes, firstPeriod);
                checkValue("restart noteValid cycles", notes, songLengthExp[3]);
                checkValue("restart first notePeriod", firstPeriod, firstPeriodExp[3]);
                apbXfer(1'b0, statusAddr, 32'h0, rdata, err);
                checkValue("status prdata", rdata, 32'h30);
                endTest("test 5 restart");

                $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("RESULT: PASS");
                end else begin
                        $display("RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
musicPkg.sv
busPkg.sv
songRom.sv
notePeriodLut.sv
songSequencer.sv
songCtrlRegs.sv
musicBoxTop.sv
musicBoxTb.sv

/* runSim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing --assert -Wno-fatal -f compile.f \
        --top-module musicBoxTb -o musicBoxSim > build.log 2>&1 \
        && ./obj_dir/musicBoxSim 2>&1 | tee sim.log \
        || { echo "build or simulation did not complete, see build.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } \
        || { echo "simulation passed"; exit 0; }
